//--- band_checker.sv
module band_checker
  import freq_mon_pkg::*;
(
  input  logic           ref_clk_i,
  input  logic           rst_i,
  input  logic           capture_i,
  input  ch_result_vec_t results_i,
  input  logic [CNT_W-1:0] low_lim_i,
  input  logic [CNT_W-1:0] high_lim_i,
  output band_status_t   status_o
);

  logic                         valid_q;
  logic [NUM_CH-1:0]            in_band_q;
  logic [NUM_CH-1:0]            in_band_d;
  logic [NUM_CH-1:0][CNT_W-1:0] counts_q;

  // ~~~~~~~~~~~~~~~~~~~~
  // limit compare
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    for (int k = 0; k < NUM_CH; k++)
    begin
      // both limits inclusive
      in_band_d[k] = (results_i[k].freq_cnt >= low_lim_i) &&
                     (results_i[k].freq_cnt <= high_lim_i);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // capture registers
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      valid_q   <= 1'b0;
      in_band_q <= '0;
    end
    else
    begin
      valid_q <= capture_i;  // one cycle pulse
      if (capture_i)
        in_band_q <= in_band_d;
    end
  end

  always_ff @(posedge ref_clk_i)
  begin
    if (capture_i)
    begin
      for (int k = 0; k < NUM_CH; k++)
      begin
        counts_q[k] <= results_i[k].freq_cnt;
      end
    end
  end

  // held until the next capture
  assign status_o.valid   = valid_q;
  assign status_o.in_band = in_band_q;
  assign status_o.counts  = counts_q;

endmodule

//--- freq_mon_pkg.sv
package freq_mon_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // sizes and timing
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int NUM_CH     = 4;   // monitored test clocks
  localparam int CNT_W      = 18;  // frequency count width
  localparam int TERM_W     = 16;  // window length width
  localparam int SETTLE_CYC = 64;  // ref cycles in reset phase
  localparam int HOLD_CYC   = 16;  // ref cycles after window before readout

  // settle/hold counter must reach the longer of the two phases
  localparam int PHASE_W = $clog2(SETTLE_CYC);

  // ~~~~~~~~~~~~~~~~~~~~
  // bundles
  // ~~~~~~~~~~~~~~~~~~~~

  // broadcast from sequencer to every channel
  typedef struct packed {
    logic              start;     // one cycle pulse
    logic [TERM_W-1:0] term_cnt;  // window length minus one
  } meas_cmd_t;

  // per channel result
  typedef struct packed {
    logic [CNT_W-1:0] freq_cnt;  // held between runs
    logic             done;      // level, low while measuring
  } ch_result_t;

  typedef ch_result_t [NUM_CH-1:0] ch_result_vec_t;

  // checker output
  typedef struct packed {
    logic                         valid;    // pulse per run
    logic [NUM_CH-1:0]            in_band;
    logic [NUM_CH-1:0][CNT_W-1:0] counts;
  } band_status_t;

endpackage

//--- freq_monitor_top.sv
module freq_monitor_top
  import freq_mon_pkg::*;
(
  input  logic              ref_clk_i,
  input  logic              rst_i,
  input  logic [NUM_CH-1:0] test_clk_i,
  input  logic              run_i,
  input  logic [TERM_W-1:0] term_cnt_i,
  input  logic [CNT_W-1:0]  low_lim_i,
  input  logic [CNT_W-1:0]  high_lim_i,
  output logic              busy_o,
  output band_status_t      status_o
);

  meas_cmd_t         cmd;
  ch_result_vec_t    results;
  logic [NUM_CH-1:0] ch_done;
  logic              capture;

  measure_sequencer u_measure_sequencer (
    .ref_clk_i  (ref_clk_i),
    .rst_i      (rst_i),
    .run_i      (run_i),
    .term_cnt_i (term_cnt_i),
    .done_i     (ch_done),
    .cmd_o      (cmd),
    .capture_o  (capture),
    .busy_o     (busy_o)
  );

  // one counter per test clock, all share the command
  for (genvar k = 0; k < NUM_CH; k++)
  begin : g_ch
    test_clk_counter u_test_clk_counter (
      .ref_clk_i  (ref_clk_i),
      .rst_i      (rst_i),
      .test_clk_i (test_clk_i[k]),
      .cmd_i      (cmd),
      .result_o   (results[k])
    );
    assign ch_done[k] = results[k].done;
  end

  band_checker u_band_checker (
    .ref_clk_i  (ref_clk_i),
    .rst_i      (rst_i),
    .capture_i  (capture),
    .results_i  (results),
    .low_lim_i  (low_lim_i),
    .high_lim_i (high_lim_i),
    .status_o   (status_o)
  );

endmodule

//--- measure_sequencer.sv
module measure_sequencer
  import freq_mon_pkg::*;
(
  input  logic              ref_clk_i,
  input  logic              rst_i,
  input  logic              run_i,
  input  logic [TERM_W-1:0] term_cnt_i,
  input  logic [NUM_CH-1:0] done_i,
  output meas_cmd_t         cmd_o,
  output logic              capture_o,
  output logic              busy_o
);

  logic              busy_q;
  logic              start_q;
  logic              arm_q;      // masks stale done levels
  logic              capture_q;
  logic [TERM_W-1:0] term_q;
  logic              accept;
  logic              all_done;

  assign accept   = run_i && !busy_q;  // requests while busy are dropped
  assign all_done = busy_q && arm_q && (&done_i);

  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      busy_q    <= 1'b0;
      start_q   <= 1'b0;
      arm_q     <= 1'b0;
      capture_q <= 1'b0;
    end
    else
    begin
      start_q   <= accept;
      arm_q     <= busy_q;  // done drops one cycle after start
      capture_q <= all_done;
      if (accept)
        busy_q <= 1'b1;
      else if (all_done)
        busy_q <= 1'b0;
    end
  end

  // window length held for the whole run
  always_ff @(posedge ref_clk_i)
  begin
    if (accept)
      term_q <= term_cnt_i;
  end

  assign cmd_o.start    = start_q;
  assign cmd_o.term_cnt = term_q;
  assign capture_o      = capture_q;
  assign busy_o         = busy_q;

endmodule

//--- rst_sync_cell.sv
module rst_sync_cell (
  input  logic clk_i,
  input  logic rst_async_i,
  output logic rst_sync_o
);

  logic meta_q;
  logic sync_q;

  // assert at once, release on the second clk_i edge
  always_ff @(posedge clk_i or posedge rst_async_i)
  begin
    if (rst_async_i)
    begin
      meta_q <= 1'b1;
      sync_q <= 1'b1;
    end
    else
    begin
      meta_q <= 1'b0;
      sync_q <= meta_q;
    end
  end

  assign rst_sync_o = sync_q;

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f verilog.f --top-module tb_freq_monitor \
  -o sim_freq_monitor > build.log 2>&1 \
  && ./obj_dir/sim_freq_monitor > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- tb_freq_monitor.sv
module tb_freq_monitor
  import freq_mon_pkg::*;
();

  localparam int TIMEOUT_CYC = 2500;               // longest window plus sequence overhead
  localparam int PERIOD [NUM_CH] = '{2, 4, 6, 10};  // test clock periods against a ref of 4

  logic              ref_clk;
  logic              rst;
  logic [NUM_CH-1:0] test_clk;
  logic              run;
  logic [TERM_W-1:0] term_cnt;
  logic [CNT_W-1:0]  low_lim;
  logic [CNT_W-1:0]  high_lim;
  logic              busy;
  band_status_t      status;

  int                err_cnt      = 0;
  int                prop_err_cnt = 0;
  int                timeout_cnt  = 0;
  int                valid_cnt    = 0;
  int                seed_ret;
  logic [TERM_W-1:0] term;
  logic [TERM_W-1:0] prev_term;

  freq_monitor_top u_freq_monitor_top (
    .ref_clk_i  (ref_clk),
    .rst_i      (rst),
    .test_clk_i (test_clk),
    .run_i      (run),
    .term_cnt_i (term_cnt),
    .low_lim_i  (low_lim),
    .high_lim_i (high_lim),
    .busy_o     (busy),
    .status_o   (status)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // clocks
  // ~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    ref_clk = 1'b0;
    forever #2 ref_clk = ~ref_clk;
  end

  initial
  begin
    test_clk = '0;
    fork
      forever #(PERIOD[0] / 2) test_clk[0] = ~test_clk[0];
      forever #(PERIOD[1] / 2) test_clk[1] = ~test_clk[1];
      forever #(PERIOD[2] / 2) test_clk[2] = ~test_clk[2];
      forever #(PERIOD[3] / 2) test_clk[3] = ~test_clk[3];
    join
  end

  always @(posedge ref_clk)
  begin
    if (status.valid)
      valid_cnt++;  // pulses seen over the whole run
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // protocol properties
  // ~~~~~~~~~~~~~~~~~~~~
  assert property (@(posedge ref_clk) disable iff (rst) status.valid |=> !status.valid)
  else
  begin
    prop_err_cnt++;
    $display("ERR status_o.valid: got 0x%h, expected 0x0", $sampled(status.valid));
  end

  // busy has already dropped when valid shows up
  assert property (@(posedge ref_clk) disable iff (rst) status.valid |-> !busy)
  else
  begin
    prop_err_cnt++;
    $display("ERR busy_o: got 0x%h, expected 0x0", $sampled(busy));
  end

  task automatic report_mismatch(input string name, input int got, input int exp);
    err_cnt++;
    $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
  endtask

  // one full run with limits placed around channels hi_idx..lo_idx
  task automatic run_measurement(input logic [TERM_W-1:0] win, input bit extra_req);
    int                exp_cnt [NUM_CH];
    int                hi_idx;
    int                lo_idx;
    int                lat;
    int                busy_fall;
    int                pulses;
    int                got;
    logic [NUM_CH-1:0] exp_mask;
    logic [NUM_CH-1:0] rule_mask;
    bit                seen;
    for (int k = 0; k < NUM_CH; k++)
      exp_cnt[k] = (int'(win) + 1) * 4 / PERIOD[k] / 4;  // edges in the window divided by four
    hi_idx = $urandom % NUM_CH;  // fastest channel inside the band
    lo_idx = hi_idx + $urandom % (NUM_CH - hi_idx);
    for (int k = 0; k < NUM_CH; k++)
      exp_mask[k] = (k >= hi_idx) && (k <= lo_idx);
    pulses = valid_cnt;
    @(posedge ref_clk);
    run      <= 1'b1;
    term_cnt <= win;
    low_lim  <= CNT_W'(exp_cnt[lo_idx] - 4);
    high_lim <= CNT_W'(exp_cnt[hi_idx] + 4);
    @(negedge ref_clk);
    assert (busy === 1'b0) else report_mismatch("busy_o", int'(busy), 0);
    @(posedge ref_clk);
    run      <= 1'b0;
    term_cnt <= ~win;  // sequencer must keep its own copy
    @(negedge ref_clk);
    assert (busy === 1'b1) else report_mismatch("busy_o", int'(busy), 1);
    lat       = 0;
    busy_fall = -1;
    seen      = 1'b0;
    while (!seen && lat < TIMEOUT_CYC)
    begin
      @(posedge ref_clk);
      if (extra_req && lat == 20)
      begin
        run      <= 1'b1;  // arrives while busy
        term_cnt <= win >> 1;
      end
      else
        run <= 1'b0;
      @(negedge ref_clk);
      lat++;
      if (!busy && busy_fall < 0)
        busy_fall = lat;
      seen = status.valid;
    end
    if (!seen)
    begin
      timeout_cnt++;
      $display("timeout: no valid pulse within %0d ref cycles of a run request", TIMEOUT_CYC);
      return;
    end
    // counted from the cycle busy rose
    assert (lat == int'(win) + 86)
    else report_mismatch("status_o.valid cycle", lat, int'(win) + 86);
    // busy falls with capture and valid follows one cycle later
    assert (busy_fall == lat - 1) else report_mismatch("busy_o fall cycle", busy_fall, lat - 1);
    for (int k = 0; k < NUM_CH; k++)
    begin
      got = int'(status.counts[k]);
      assert (got >= exp_cnt[k] - 3 && got <= exp_cnt[k] + 3)
      else report_mismatch($sformatf("status_o.counts[%0d]", k), got, exp_cnt[k]);
      rule_mask[k] = (status.counts[k] >= low_lim) && (status.counts[k] <= high_lim);
    end
    assert (status.in_band == rule_mask)
    else report_mismatch("status_o.in_band", int'(status.in_band), int'(rule_mask));
    assert (status.in_band == exp_mask)
    else report_mismatch("status_o.in_band", int'(status.in_band), int'(exp_mask));
    repeat (3) @(negedge ref_clk);
    assert (valid_cnt - pulses == 1)
    else report_mismatch("status_o.valid pulses", valid_cnt - pulses, 1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    seed_ret = $urandom(32'h7fd6_c88b);
    rst      <= 1'b1;
    run      <= 1'b0;
    term_cnt <= '0;
    low_lim  <= '0;
    high_lim <= '0;
    prev_term = '0;
    repeat (5) @(posedge ref_clk);
    rst <= 1'b0;
    repeat (40)
    begin
      @(negedge ref_clk);
      assert (!busy && !status.valid)
      else report_mismatch("busy_o/status_o.valid", int'({busy, status.valid}), 0);
    end
    // back to back runs where the third gets a stray request
    for (int i = 0; i < 5; i++)
    begin
      term = TERM_W'(200 + $urandom % 1801);
      if (term == prev_term)
        term = term + 1'b1;
      run_measurement(term, i == 2);
      prev_term = term;
    end
    $display("errors: value %0d, property %0d, timeout %0d", err_cnt, prop_err_cnt, timeout_cnt);
    if (err_cnt == 0 && prop_err_cnt == 0 && timeout_cnt == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- test_clk_counter.sv
module test_clk_counter
  import freq_mon_pkg::*;
(
  input  logic       ref_clk_i,
  input  logic       rst_i,
  input  logic       test_clk_i,
  input  meas_cmd_t  cmd_i,
  output ch_result_t result_o
);

  // one-hot state bits
  localparam int RESET_ST   = 0;
  localparam int MEASURE_ST = 1;
  localparam int HOLD_ST    = 2;
  localparam int UPDATE_ST  = 3;
  localparam int DONE_ST    = 4;

  logic [4:0]         state_q;
  logic [4:0]         state_d;
  logic [PHASE_W-1:0] phase_cnt_q;  // shared settle / hold count
  logic [TERM_W-1:0]  win_cnt_q;
  logic [CNT_W-1:0]   freq_cnt_q;
  logic               done_q;

  logic               tst_rst;
  logic               tst_en;
  logic               rst_meta_q;
  logic               rst_dly_q;
  logic               en_meta_q;
  logic               en_dly_q;
  logic [3:0]         ring_q;
  logic               cnt_rst;
  logic [CNT_W-1:0]   edge_cnt_q;

  // ~~~~~~~~~~~~~~~~~~~~
  // ref clock domain
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb
  begin
    state_d = '0;
    if (cmd_i.start)
      state_d[RESET_ST] = 1'b1;  // restart from any state
    else
    begin
      case (1'b1)
        state_q[RESET_ST]:
        begin
          if (phase_cnt_q == PHASE_W'(SETTLE_CYC - 1))
            state_d[MEASURE_ST] = 1'b1;
          else
            state_d[RESET_ST] = 1'b1;
        end
        state_q[MEASURE_ST]:
        begin
          if (win_cnt_q == cmd_i.term_cnt)
            state_d[HOLD_ST] = 1'b1;
          else
            state_d[MEASURE_ST] = 1'b1;
        end
        state_q[HOLD_ST]:
        begin
          if (phase_cnt_q == PHASE_W'(HOLD_CYC - 1))
            state_d[UPDATE_ST] = 1'b1;
          else
            state_d[HOLD_ST] = 1'b1;
        end
        state_q[UPDATE_ST]:
          state_d[DONE_ST] = 1'b1;
        default:
          state_d[DONE_ST] = 1'b1;  // idle until next start
      endcase
    end
  end

  always_ff @(posedge ref_clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q     <= 5'b1 << DONE_ST;  // idle, runs only on request
      phase_cnt_q <= '0;
      win_cnt_q   <= '0;
      freq_cnt_q  <= '0;
      done_q      <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (cmd_i.start || !(state_q[RESET_ST] || state_q[HOLD_ST]))
        phase_cnt_q <= '0;
      else
        phase_cnt_q <= phase_cnt_q + 1'b1;
      win_cnt_q <= state_q[MEASURE_ST] ? win_cnt_q + 1'b1 : '0;
      if (state_q[UPDATE_ST])
        freq_cnt_q <= edge_cnt_q;  // count has settled by now
      done_q <= state_q[DONE_ST] && !cmd_i.start;
    end
  end

  assign tst_rst = state_q[RESET_ST];
  assign tst_en  = state_q[MEASURE_ST];

  assign result_o.freq_cnt = freq_cnt_q;
  assign result_o.done     = done_q;

  // ~~~~~~~~~~~~~~~~~~~~
  // test clock domain
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge test_clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      rst_meta_q <= 1'b0;
      rst_dly_q  <= 1'b0;
      en_meta_q  <= 1'b0;
      en_dly_q   <= 1'b0;
    end
    else
    begin
      rst_meta_q <= tst_rst;
      rst_dly_q  <= rst_meta_q;
      en_meta_q  <= tst_en;
      en_dly_q   <= en_meta_q;
    end
  end

  // divide by four ring
  always_ff @(posedge test_clk_i or posedge rst_i)
  begin
    if (rst_i)
      ring_q <= 4'b0001;
    else if (rst_dly_q)
      ring_q <= 4'b0001;
    else
      ring_q <= {ring_q[2:0], ring_q[3]};
  end

  rst_sync_cell u_rst_sync_cell (
    .clk_i       (test_clk_i),
    .rst_async_i (rst_i | tst_rst),
    .rst_sync_o  (cnt_rst)
  );

  always_ff @(posedge test_clk_i or posedge cnt_rst)
  begin
    if (cnt_rst)
      edge_cnt_q <= '0;
    else if (en_dly_q && ring_q[3])
      edge_cnt_q <= edge_cnt_q + 1'b1;  // one per four test edges
  end

endmodule

//--- verilog.f
freq_mon_pkg.sv
rst_sync_cell.sv
test_clk_counter.sv
measure_sequencer.sv
band_checker.sv
freq_monitor_top.sv
tb_freq_monitor.sv
